/* list.f */
verilog/wave_pkg.sv
verilog/fifo_pkg.sv
verilog/gray_sync.sv
verilog/wave_fifo_async.sv
verilog/fifo_long.sv
verilog/trigger_word_capture.sv
verilog/wave_capture_top.sv
sim/tb_clock_gen.sv
sim/wave_checker.sv
sim/tb_wave_capture.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the wave capture testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_wave_capture -f list.f -o vsim
out=$(./obj_dir/vsim)
echo "$out"
echo "$out" | grep -q "^Everything OK$"

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

// Clocks and power on reset for the wave capture testbench
module tb_clock_gen (
  input  logic pop_en,   // Low parks pop_clk low
  output logic pipe_clk,
  output logic pop_clk,
  output logic reset
);

  initial begin
    pipe_clk = 1'b0;
    pop_clk  = 1'b0;
    reset    = 1'b1;
  end

  always #4 pipe_clk = ~pipe_clk; // 8 ns period

  // 12 ns period, stops only after a falling edge
  always #6 begin
    if (pop_en || pop_clk) begin
      pop_clk = ~pop_clk;
    end
  end

  initial begin
    repeat (16) @(posedge pipe_clk);
    reset <= 1'b0; // Released on an edge like any other input
  end

endmodule

/* sim/tb_wave_capture.sv */
`timescale 1ns/100ps

// Testbench top, runs the command lines of the vectors file
module tb_wave_capture;
  import wave_pkg::*;

  logic       pipe_clk, pop_clk, reset;
  logic       pop_en;
  logic       pipe_in_write, trig_write, trig_mode;
  pipe_word_t pipe_in_data, trig_data;
  trig_half_t trig_sel;
  wave_word_t wave;
  logic       wave_valid, fifo_full, almost_full, n_fifo_almost_em;
  string      lines[$];   // Command lines, comments dropped
  logic       loaded = 1'b0;

  tb_clock_gen u_clk (.pop_en(pop_en), .pipe_clk(pipe_clk), .pop_clk(pop_clk), .reset(reset));

  wave_capture_top #(.ADDR_BITS(3), .AF_MARGIN(4)) DUT (
    .reset(reset), .pipe_clk(pipe_clk), .pop_clk(pop_clk),
    .pipe_in_write(pipe_in_write), .pipe_in_data(pipe_in_data),
    .trig_write(trig_write), .trig_sel(trig_sel), .trig_data(trig_data),
    .trig_mode(trig_mode), .wave(wave), .wave_valid(wave_valid),
    .fifo_full(fifo_full), .almost_full(almost_full), .n_fifo_almost_em(n_fifo_almost_em)
  );

  wave_checker u_check (
    .pipe_clk(pipe_clk), .pop_clk(pop_clk), .reset(reset), .wave(wave),
    .wave_valid(wave_valid), .fifo_full(fifo_full), .almost_full(almost_full),
    .n_fifo_almost_em(n_fifo_almost_em)
  );

  ////////////////////////////////
  // Host side drivers
  ////////////////////////////////

  task automatic write_halfword(input pipe_word_t d, input bit with_gap);
    @(posedge pipe_clk);
    pipe_in_write <= 1'b1;
    pipe_in_data  <= d;
    @(posedge pipe_clk);        // Accepted here
    pipe_in_write <= 1'b0;
    if (with_gap) begin
      repeat ($urandom % 3) @(posedge pipe_clk); // Random idle gap
    end
  endtask

  task automatic write_trigger(input logic sel, input pipe_word_t d);
    @(posedge pipe_clk);
    trig_write <= 1'b1;
    trig_sel   <= trig_half_t'(sel);
    trig_data  <= d;
    @(posedge pipe_clk);
    trig_write <= 1'b0;
  endtask

  // Pop side parked, so the write side count only grows
  task automatic fill_to_full(input int held);
    int n;
    n = held;
    pop_en <= 1'b0;
    repeat (4) @(posedge pipe_clk);
    while (!fifo_full && n < 32) begin
      write_halfword(pipe_word_t'(16'hf000 + n - held), 1'b0);
      n++;
      @(negedge pipe_clk);
      u_check.check_value("almost_full", 32'(n >= 12), 32'(almost_full));
      u_check.check_value("fifo_full", 32'(n >= 16), 32'(fifo_full));
    end
    write_halfword(16'hdead, 1'b0); // Dropped, later words must not see it
    @(negedge pipe_clk);
    u_check.check_value("fifo_full", 32'(1), 32'(fifo_full));
    pop_en <= 1'b1;
  endtask

  ////////////////////////////////
  // Command loop
  ////////////////////////////////

  initial begin
    int         fd;
    int         burst_start;
    string      line;
    byte        cmd;
    logic [31:0] a, b;
    void'($urandom(32'h4a68b43d));
    pipe_in_write = 1'b0;
    pipe_in_data  = '0;
    trig_write    = 1'b0;
    trig_sel      = TRIG_LOW;
    trig_data     = '0;
    trig_mode     = 1'b0;
    pop_en        = 1'b1;
    burst_start   = 0;
    fd = $fopen("sim/wave_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open sim/wave_vectors.txt");
      u_check.other_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          if (line[0] == "E") begin
            // Expected words queued ahead of the burst that pops them
            lines.insert(burst_start, line);
            burst_start++;
          end else begin
            lines.push_back(line);
            if (line[0] == "D") begin
              burst_start = lines.size(); // Idle wait closes a burst
            end
          end
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    @(negedge reset);
    foreach (lines[i]) begin
      a = '0;
      b = '0;
      void'($sscanf(lines[i], "%c %h %h", cmd, a, b));
      case (cmd)
        "W": write_halfword(a[15:0], 1'b1);
        "T": write_trigger(a[0], b[15:0]);
        "M": begin
          @(posedge pipe_clk);
          trig_mode <= a[0];
        end
        "E": u_check.expect_word(a);
        "C": begin
          @(negedge pipe_clk);
          u_check.check_value("wave", a, wave);
        end
        "F": fill_to_full(int'(a));
        "D": repeat (a) @(posedge pipe_clk);
        default: begin
          $display("Unknown command in vectors line: %s", lines[i]);
          u_check.other_errors++;
        end
      endcase
    end
    u_check.end_check();
    $display("Checks done, %0d value errors, %0d other errors",
             u_check.value_errors, u_check.other_errors);
    if (u_check.value_errors + u_check.other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog, 64 pipe_clk periods per command plus reset
  initial begin
    wait (loaded);
    #((lines.size() * 64 + 16) * 8);
    $display("Run did not finish in time, watchdog stopped it");
    $display("Something failed");
    $finish;
  end

endmodule

/* sim/wave_checker.sv */
`timescale 1ns/100ps

// Watches the DUT outputs and keeps the error counts
module wave_checker (
  input  logic                 pipe_clk,
  input  logic                 pop_clk,
  input  logic                 reset,
  input  wave_pkg::wave_word_t wave,
  input  logic                 wave_valid,
  input  logic                 fifo_full,
  input  logic                 almost_full,
  input  logic                 n_fifo_almost_em
);
  import wave_pkg::*;

  wave_word_t expect_q[$]; // Wave words still to come, in write order
  int         value_errors = 0;
  int         other_errors = 0;

  ////////////////////////////////
  // Helpers called by the top
  ////////////////////////////////

  task automatic expect_word(input wave_word_t w);
    expect_q.push_back(w);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("error: %s expected %h got %h", name, exp, act);
      value_errors++;
    end
  endtask

  // Anything left over never showed up on wave
  task automatic end_check();
    if (expect_q.size() != 0) begin
      $display("%0d expected wave words never appeared, next one %h",
               expect_q.size(), expect_q[0]);
      other_errors++;
    end
  endtask

  ////////////////////////////////
  // State right after reset
  ////////////////////////////////

  initial begin
    @(negedge reset);
    repeat (6) @(negedge pipe_clk); // Pop side reset is two pop_clk flops behind
    check_value("wave_valid", 32'(0), 32'(wave_valid));
    check_value("fifo_full", 32'(0), 32'(fifo_full));
    check_value("almost_full", 32'(0), 32'(almost_full));
    check_value("n_fifo_almost_em", 32'(1), 32'(n_fifo_almost_em));
    check_value("wave", 32'(0), wave);
  end

  ////////////////////////////////
  // Wave words on every pop
  ////////////////////////////////

  // Sampled mid cycle, away from the pop_clk edge
  always @(negedge pop_clk) begin
    if (!reset && wave_valid) begin
      if (expect_q.size() == 0) begin
        $display("wave_valid pulsed with no wave word expected, wave is %h", wave);
        other_errors++;
      end else begin
        check_value("wave", expect_q.pop_front(), wave);
      end
    end
  end

  // Full without almost full breaks the flag ordering
  always @(negedge pipe_clk) begin
    if (!reset && fifo_full && !almost_full) begin
      $display("fifo_full is high while almost_full is low");
      other_errors++;
    end
  end

endmodule

/* sim/wave_vectors.txt */
# cmd operands in hex: W data, T half data, M mode, E wave word, C wave now,
# F halfwords already held then fill, D pipe_clk cycles
D 8
W 1111
W 2222
W 3333
W 4444
W 5555
E 22221111
D 40
W 6666
E 44443333
W 7777
W 8888
E 66665555
D 40
F 2
E 88887777
E f001f000
E f003f002
E f005f004
E f007f006
E f009f008
E f00bf00a
D 60
M 1
T 0 beef
T 1 dead
D 4
C deadbeef
M 0
D 4
C f00bf00a
W f00e
W f00f
E f00df00c
D 40

/* verilog/fifo_long.sv */
`timescale 1ns/100ps

// FIFO wrapper, free running read and trigger override on wave
module fifo_long #(
  parameter int ADDR_BITS = fifo_pkg::DEFAULT_ADDR_BITS,
  parameter int AF_MARGIN = fifo_pkg::DEFAULT_AF_MARGIN
) (
  input  logic                 reset,
  input  logic                 pipe_clk,
  input  logic                 pop_clk,
  input  logic                 pipe_in_write,    // One cycle strobe
  input  wave_pkg::pipe_word_t pipe_in_data,
  input  logic                 is_from_trigger,  // Quasi-static select
  input  wave_pkg::wave_word_t data_from_trig,   // Quasi-static into pop_clk
  output wave_pkg::wave_word_t wave,
  output logic                 wave_valid,       // pop_clk pulse, FIFO pops only
  output logic                 fifofull,
  output logic                 almostfifofull1,
  output logic                 n_fifo_almost_em  // High with one sample or less
);
  import wave_pkg::*;

  wave_word_t fifo_wave; // Last popped sample
  logic       fifo_rden;

  ////////////////////////////////
  // Read control
  ////////////////////////////////

  // Pop whenever two or more samples are visible
  // so the newest sample waits for its successor
  assign fifo_rden = ~n_fifo_almost_em;

  wave_fifo_async #(
    .ADDR_BITS (ADDR_BITS),
    .AF_MARGIN (AF_MARGIN)
  ) u_fifo (
    .reset        (reset),
    .pipe_clk     (pipe_clk),
    .pop_clk      (pop_clk),
    .wr_data      (pipe_in_data),
    .wr_en        (pipe_in_write),
    .rd_en        (fifo_rden),
    .rd_data      (fifo_wave),
    .rd_valid     (wave_valid),
    .full         (fifofull),
    .almost_full  (almostfifofull1),
    .almost_empty (n_fifo_almost_em)
  );

  ////////////////////////////////
  // Output select
  ////////////////////////////////

  // Trigger word wins while in trigger mode
  assign wave = is_from_trigger ? data_from_trig : fifo_wave;

endmodule

/* verilog/fifo_pkg.sv */
// FIFO geometry defaults and the helpers that size it

package fifo_pkg;

  // log2 of depth in 32-bit samples, 1024 samples by default
  localparam int DEFAULT_ADDR_BITS = 10;

  // Free halfword slots left when almost full rises
  localparam int DEFAULT_AF_MARGIN = 4;

  // Depth in halfwords, two per sample
  function automatic int hw_depth(int addr_bits);
    return 2 ** (addr_bits + 1);
  endfunction

  // Write side halfword count at which almost full goes high
  function automatic int af_level(int addr_bits, int margin);
    return hw_depth(addr_bits) - margin;
  endfunction

endpackage

/* verilog/gray_sync.sv */
`timescale 1ns/100ps

// Two flop synchronizer for a gray coded pointer, decoded back to binary
module gray_sync #(
  parameter int WIDTH = 4
) (
  input  logic             dst_clk,
  input  logic             dst_reset,
  input  logic [WIDTH-1:0] src_bin,  // Source side register, already gray coded
  output logic [WIDTH-1:0] dst_bin
);

  logic [WIDTH-1:0] sync_meta; // First stage, may go metastable
  logic [WIDTH-1:0] sync_gray; // Settled gray value

  function automatic logic [WIDTH-1:0] gray2bin(logic [WIDTH-1:0] g);
    logic [WIDTH-1:0] b;
    b[WIDTH-1] = g[WIDTH-1];
    for (int i = WIDTH - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i]; // Running xor from the top bit down
    end
    return b;
  endfunction

  always_ff @(posedge dst_clk) begin
    if (dst_reset) begin
      sync_meta <= '0;
      sync_gray <= '0;
    end else begin
      sync_meta <= src_bin;
      sync_gray <= sync_meta;
    end
  end

  assign dst_bin = gray2bin(sync_gray); // Back to binary for compares

  // Source must step slower than dst_clk samples it
  a_gray_one_step: assert property (@(posedge dst_clk) disable iff (dst_reset)
    $countones(sync_gray ^ $past(sync_gray)) <= 1)
    else $error("gray_sync: synchronized pointer moved more than one step");

endmodule

/* verilog/trigger_word_capture.sv */
`timescale 1ns/100ps

// Builds the 32-bit trigger word from two host halves
module trigger_word_capture (
  input  logic                 reset,
  input  logic                 pipe_clk,
  input  logic                 trig_write,    // Strobe for trig_sel and trig_data
  input  wave_pkg::trig_half_t trig_sel,
  input  wave_pkg::pipe_word_t trig_data,
  input  logic                 trig_mode_in,  // Level from host
  output wave_pkg::wave_word_t trig_word,
  output logic                 trig_mode
);
  import wave_pkg::*;

  ////////////////////////////////
  // Half word capture
  ////////////////////////////////

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      trig_word <= '0;
      trig_mode <= 1'b0;  // FIFO data on wave after reset
    end else begin
      trig_mode <= trig_mode_in;
      if (trig_write) begin
        case (trig_sel)
          TRIG_LOW:  trig_word[PIPE_WORD_BITS-1:0] <= trig_data;
          TRIG_HIGH: trig_word[WAVE_WORD_BITS-1:PIPE_WORD_BITS] <= trig_data;
        endcase
      end
    end
  end

  // Word and mode feed the pop_clk mux without sync
  // host changes them only while wave is idle

  // Half select must be a defined value on every strobe
  // both codes name a half
  a_trig_sel_legal: assert property (@(posedge pipe_clk) disable iff (reset)
    trig_write |-> !$isunknown(trig_sel))
    else $error("trigger_word_capture: illegal trig_sel on write");

endmodule

/* verilog/wave_capture_top.sv */
`timescale 1ns/100ps

// Host to waveform buffer, trigger capture plus packing FIFO
module wave_capture_top #(
  parameter int ADDR_BITS = fifo_pkg::DEFAULT_ADDR_BITS,
  parameter int AF_MARGIN = fifo_pkg::DEFAULT_AF_MARGIN
) (
  input  logic                 reset,
  input  logic                 pipe_clk,
  input  logic                 pop_clk,
  input  logic                 pipe_in_write,
  input  wave_pkg::pipe_word_t pipe_in_data,
  input  logic                 trig_write,
  input  wave_pkg::trig_half_t trig_sel,
  input  wave_pkg::pipe_word_t trig_data,
  input  logic                 trig_mode,
  output wave_pkg::wave_word_t wave,
  output logic                 wave_valid,
  output logic                 fifo_full,
  output logic                 almost_full,
  output logic                 n_fifo_almost_em
);
  import wave_pkg::*;

  wave_word_t trig_word;   // Assembled trigger word
  logic       trig_mode_q; // Registered mode level

  trigger_word_capture u_trig (
    .reset        (reset),
    .pipe_clk     (pipe_clk),
    .trig_write   (trig_write),
    .trig_sel     (trig_sel),
    .trig_data    (trig_data),
    .trig_mode_in (trig_mode),
    .trig_word    (trig_word),
    .trig_mode    (trig_mode_q)
  );

  fifo_long #(
    .ADDR_BITS (ADDR_BITS),
    .AF_MARGIN (AF_MARGIN)
  ) u_fifo_long (
    .reset            (reset),
    .pipe_clk         (pipe_clk),
    .pop_clk          (pop_clk),
    .pipe_in_write    (pipe_in_write),
    .pipe_in_data     (pipe_in_data),
    .is_from_trigger  (trig_mode_q),
    .data_from_trig   (trig_word),
    .wave             (wave),
    .wave_valid       (wave_valid),
    .fifofull         (fifo_full),
    .almostfifofull1  (almost_full),
    .n_fifo_almost_em (n_fifo_almost_em)
  );

endmodule

/* verilog/wave_fifo_async.sv */
`timescale 1ns/100ps

// Dual clock FIFO, halfwords in on pipe_clk, samples out on pop_clk
module wave_fifo_async #(
  parameter int ADDR_BITS = fifo_pkg::DEFAULT_ADDR_BITS,
  parameter int AF_MARGIN = fifo_pkg::DEFAULT_AF_MARGIN
) (
  input  logic                 reset,
  input  logic                 pipe_clk,
  input  logic                 pop_clk,
  input  wave_pkg::pipe_word_t wr_data,
  input  logic                 wr_en,
  input  logic                 rd_en,
  output wave_pkg::wave_word_t rd_data,
  output logic                 rd_valid,     // One pop_clk pulse per popped sample
  output logic                 full,         // pipe_clk domain
  output logic                 almost_full,  // pipe_clk domain
  output logic                 almost_empty  // pop_clk domain, at most one sample seen
);
  import wave_pkg::*;
  import fifo_pkg::*;

  localparam int HW_DEPTH = hw_depth(ADDR_BITS);            // Halfword slots
  localparam int HW_PTR_W = ADDR_BITS + 2;                  // Halfword ptr plus wrap bit
  localparam int SP_W     = ADDR_BITS + 1;                  // Sample ptr plus wrap bit
  localparam int AF_LEVEL = af_level(ADDR_BITS, AF_MARGIN);

  function automatic logic [SP_W-1:0] bin2gray(logic [SP_W-1:0] b);
    return b ^ (b >> 1);
  endfunction

  pipe_word_t mem [HW_DEPTH]; // Halfword storage, read in pairs

  ////////////////////////////////
  // Write side, pipe_clk
  ////////////////////////////////

  logic [HW_PTR_W-1:0] wr_ptr;
  logic [HW_PTR_W-1:0] wr_ptr_next;
  logic [SP_W-1:0]     wr_gray;     // Sample ptr, gray, crosses to pop side
  logic [SP_W-1:0]     rd_sp_sync;  // Read sample ptr seen from write side
  logic [HW_PTR_W-1:0] wr_count;    // Halfwords held, pessimistic
  logic                wr_accept;

  assign wr_accept   = wr_en && !full; // Write while full just drops the word
  assign wr_ptr_next = wr_ptr + HW_PTR_W'(wr_accept);

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
    end else begin
      wr_ptr  <= wr_ptr_next;
      // Sample ptr moves only when the high halfword lands
      wr_gray <= bin2gray(wr_ptr_next[HW_PTR_W-1:1]);
    end
  end

  always_ff @(posedge pipe_clk) begin
    if (wr_accept) begin
      mem[wr_ptr[HW_PTR_W-2:0]] <= wr_data;
    end
  end

  assign wr_count    = wr_ptr - {rd_sp_sync, 1'b0};       // Read ptr in halfwords
  assign full        = wr_count[HW_PTR_W-1];              // Set only at count == depth
  assign almost_full = wr_count >= HW_PTR_W'(AF_LEVEL);

  ////////////////////////////////
  // Read side, pop_clk
  ////////////////////////////////

  logic [1:0]      rst_sync;   // Reset carried into pop_clk
  logic            rd_reset;
  logic [SP_W-1:0] rd_ptr;
  logic [SP_W-1:0] rd_ptr_next;
  logic [SP_W-1:0] rd_gray;    // Crosses to write side
  logic [SP_W-1:0] wr_sp_sync; // Write sample ptr seen from read side
  logic [SP_W-1:0] rd_count;   // Complete samples visible here
  logic            rd_fire;

  always_ff @(posedge pop_clk) begin
    rst_sync <= {rst_sync[0], reset};
  end
  assign rd_reset = rst_sync[1];

  assign rd_count     = wr_sp_sync - rd_ptr;
  assign almost_empty = rd_count <= SP_W'(1);
  assign rd_fire      = rd_en && (rd_count != '0); // Never pop past empty
  assign rd_ptr_next  = rd_ptr + SP_W'(1);

  always_ff @(posedge pop_clk) begin
    if (rd_reset) begin
      rd_ptr   <= '0;
      rd_gray  <= '0;
      rd_valid <= 1'b0;
      rd_data  <= '0; // Wave reads zero after reset
    end else begin
      rd_valid <= rd_fire;
      if (rd_fire) begin
        rd_ptr  <= rd_ptr_next;
        rd_gray <= bin2gray(rd_ptr_next);
        // High halfword was written second
        rd_data <= {mem[{rd_ptr[ADDR_BITS-1:0], 1'b1}], mem[{rd_ptr[ADDR_BITS-1:0], 1'b0}]};
      end
    end
  end

  ////////////////////////////////
  // Pointer crossings
  ////////////////////////////////

  gray_sync #(.WIDTH(SP_W)) u_wr_to_rd (
    .dst_clk   (pop_clk),
    .dst_reset (rd_reset),
    .src_bin   (wr_gray),
    .dst_bin   (wr_sp_sync)
  );

  gray_sync #(.WIDTH(SP_W)) u_rd_to_wr (
    .dst_clk   (pipe_clk),
    .dst_reset (reset),
    .src_bin   (rd_gray),
    .dst_bin   (rd_sp_sync)
  );

  // Count above the depth means a write got in while full
  a_no_write_full: assert property (@(posedge pipe_clk) disable iff (reset)
    wr_count <= HW_PTR_W'(HW_DEPTH))
    else $error("wave_fifo_async: write accepted while full");

  // Read enable comes from outside and must respect almost empty
  a_no_read_almost_empty: assert property (@(posedge pop_clk) disable iff (rd_reset)
    rd_en |-> !almost_empty)
    else $error("wave_fifo_async: read while almost empty");

endmodule

/* verilog/wave_pkg.sv */
// Data formats shared by the host side, the FIFO and the wave output

package wave_pkg;

  ////////////////////////////////
  // Word widths
  ////////////////////////////////

  localparam int PIPE_WORD_BITS = 16;                 // One host transfer
  localparam int WAVE_WORD_BITS = 2 * PIPE_WORD_BITS; // Two halfwords per sample

  // Host data word, written on pipe_clk
  typedef logic [PIPE_WORD_BITS-1:0] pipe_word_t;

  // Packed sample, low halfword arrives first
  typedef logic [WAVE_WORD_BITS-1:0] wave_word_t;

  ////////////////////////////////
  // Trigger word half select
  ////////////////////////////////

  // Which half of the trigger word a host strobe lands in
  typedef enum logic {
    TRIG_LOW  = 1'b0, // Bits 15:0
    TRIG_HIGH = 1'b1  // Bits 31:16
  } trig_half_t;

endpackage
